// ==== dv/mrnw_asserts.sv ====
`timescale 1ns/10ps
`include "mrnw_defs.svh"

module mrnw_asserts import mrnw_pkg::*; (
  input logic                    clk,
  input logic                    rst,
  input wr_cmd_t                 ent_q [`MRNW_CACHE_DEPTH],
  input logic [`MRNW_NUM_WR-1:0] park,
  input logic [`MRNW_NUM_WR-1:0] park_found
);

  logic [`MRNW_CACHE_DEPTH-1:0] ent_valid;
  logic                         dup_addr;  // Two live entries share one address.

  always_comb begin
    dup_addr = 1'b0;
    for (int i = 0; i < `MRNW_CACHE_DEPTH; i++) begin
      ent_valid[i] = ent_q[i].wr;
      for (int j = i + 1; j < `MRNW_CACHE_DEPTH; j++) begin
        if (ent_q[i].wr && ent_q[j].wr && (ent_q[i].addr == ent_q[j].addr)) begin
          dup_addr = 1'b1;
        end
      end
    end
  end

  // Every write that meets a read at its address needs an entry to park in.
  park_has_room: assert property (@(posedge clk) disable iff (rst)
    ((park & ~park_found) == '0))
    else $error("A collision found no free cache entry.");

  no_dup_entry: assert property (@(posedge clk) disable iff (rst) !dup_addr)
    else $error("Two valid cache entries hold the same address.");

  empty_after_rst: assert property (@(posedge clk) $past(rst) |-> (ent_valid == '0))
    else $error("Cache entries are valid right after reset.");

endmodule

bind pseudo_port_cache mrnw_asserts u_asserts (
  .clk        (clk),
  .rst        (rst),
  .ent_q      (ent_q),
  .park       (park),
  .park_found (park_found)
);

// ==== dv/tb_mrnw.sv ====
`timescale 1ns/10ps
`include "mrnw_defs.svh"

module tb_mrnw import mrnw_pkg::*; ();

  localparam int CLK_PERIOD   = 100;
  localparam int RST_CYCLES   = 3;
  localparam int NUM_WORDS    = 1 << `MRNW_ADDR_BITS;
  localparam int P2_CYCLES    = 400;
  localparam int P3_CYCLES    = 400;
  localparam int P4_ITERS     = 64;
  localparam int P5_ITERS     = 64;
  localparam int DRAIN_CYCLES = 4;
  // Fill and read back take NUM_WORDS cycles together with two ports each.
  localparam int TOTAL_CYCLES = RST_CYCLES + 1 + NUM_WORDS + P2_CYCLES + P3_CYCLES +
                                2 * P4_ITERS + 2 * P5_ITERS + DRAIN_CYCLES;

  typedef logic [`MRNW_ADDR_BITS-1:0] addr_v_t;

  // What one read port must return once its data arrives.
  typedef struct packed {
    logic    vld;
    addr_v_t addr;
    data_t   data;
    logic    chk_fwd;
    logic    fwd;
  } exp_t;

  logic      clk;
  logic      rst;
  wr_cmd_t   wr_cmd  [`MRNW_NUM_WR];
  rd_cmd_t   rd_cmd  [`MRNW_NUM_RD];
  data_t     rd_dout [`MRNW_NUM_RD];
  logic      [`MRNW_NUM_RD-1:0] rd_fwrd;
  mem_addr_t rd_padr [`MRNW_NUM_RD];

  integer                  seed;
  data_t                   model [NUM_WORDS];  // Reference memory.
  logic [NUM_WORDS-1:0]    coll_prev;          // Addresses that collided last cycle.
  logic                    any_coll;
  wr_cmd_t                 nxt_wr [`MRNW_NUM_WR];
  rd_cmd_t                 nxt_rd [`MRNW_NUM_RD];
  exp_t [`MRNW_NUM_RD-1:0] exp_q [$];

  mrnw_mem u_mrnw_mem (
    .clk     (clk),
    .rst     (rst),
    .wr_cmd  (wr_cmd),
    .rd_cmd  (rd_cmd),
    .rd_dout (rd_dout),
    .rd_fwrd (rd_fwrd),
    .rd_padr (rd_padr)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, want);
      $display("*** FAILED ***");
      $fatal(1, "Value mismatch on a read port.");
    end
  endtask

  function automatic addr_v_t rand_addr();
    logic [31:0] r;
    r = $random(seed);
    return r[`MRNW_ADDR_BITS-1:0];
  endfunction

  function automatic data_t rand_word();
    return $random(seed);
  endfunction

  function automatic void apply_write(wr_cmd_t c);
    addr_v_t a;
    a = c.addr;
    model[a] = (model[a] & ~c.mask) | (c.data & c.mask);
  endfunction

  task automatic set_write(int w, logic en, addr_v_t a, mask_t m, data_t d);
    nxt_wr[w].wr   = en;
    nxt_wr[w].addr = a;
    nxt_wr[w].mask = m;
    nxt_wr[w].data = d;
  endtask

  task automatic set_read(int r, logic en, addr_v_t a);
    nxt_rd[r].rd   = en;
    nxt_rd[r].addr = a;
  endtask

  task automatic clear_next();
    for (int w = 0; w < `MRNW_NUM_WR; w++) set_write(w, 1'b0, '0, '0, '0);
    for (int r = 0; r < `MRNW_NUM_RD; r++) set_read(r, 1'b0, '0);
  endtask

  task automatic check_returns(input exp_t [`MRNW_NUM_RD-1:0] e);
    addr_v_t padr_v;
    for (int r = 0; r < `MRNW_NUM_RD; r++) begin
      if (e[r].vld) begin
        padr_v = rd_padr[r];
        check_value($sformatf("rd_dout[%0d]", r), rd_dout[r], e[r].data);
        check_value($sformatf("rd_padr[%0d]", r), {24'd0, padr_v}, {24'd0, e[r].addr});
        if (e[r].chk_fwd) begin
          check_value($sformatf("rd_fwrd[%0d]", r), {31'd0, rd_fwrd[r]}, {31'd0, e[r].fwd});
        end
      end
    end
  endtask

  // One clock cycle: check the reads of two cycles ago, then drive the next commands.
  task automatic run_cycle();
    exp_t [`MRNW_NUM_RD-1:0] exp_now;
    logic [NUM_WORDS-1:0]    coll_now;
    addr_v_t                 a;
    @(negedge clk);
    if (exp_q.size() == `MRNW_SRAM_DELAY) begin
      check_returns(exp_q.pop_front());
    end
    coll_now = '0;
    for (int r = 0; r < `MRNW_NUM_RD; r++) begin
      a = nxt_rd[r].addr;
      exp_now[r].vld  = nxt_rd[r].rd;
      exp_now[r].addr = a;
      exp_now[r].data = model[a];  // Value before this cycle's writes.
      exp_now[r].chk_fwd = !any_coll || coll_prev[a];
      exp_now[r].fwd     = any_coll && coll_prev[a];
      for (int w = 0; w < `MRNW_NUM_WR; w++) begin
        if (nxt_rd[r].rd && nxt_wr[w].wr && (nxt_wr[w].addr == nxt_rd[r].addr)) begin
          coll_now[a] = 1'b1;
        end
      end
    end
    for (int w = 0; w < `MRNW_NUM_WR; w++) begin
      if (nxt_wr[w].wr) apply_write(nxt_wr[w]);  // Port 1 last, so it wins.
    end
    if (|coll_now) any_coll = 1'b1;
    coll_prev = coll_now;
    exp_q.push_back(exp_now);
    wr_cmd = nxt_wr;
    rd_cmd = nxt_rd;
  endtask

  task automatic fill_memory();
    for (int i = 0; i < NUM_WORDS / 2; i++) begin
      clear_next();
      set_write(0, 1'b1, addr_v_t'(2 * i), '1, rand_word());
      set_write(1, 1'b1, addr_v_t'(2 * i + 1), '1, rand_word());
      run_cycle();
    end
  endtask

  task automatic read_all();
    for (int i = 0; i < NUM_WORDS / 2; i++) begin
      clear_next();
      set_read(0, 1'b1, addr_v_t'(2 * i));
      set_read(1, 1'b1, addr_v_t'(2 * i + 1));
      run_cycle();
    end
  endtask

  // Reads never touch an address written in the same cycle.
  task automatic random_writes();
    logic [31:0] r;
    addr_v_t     wa0;
    addr_v_t     wa1;
    addr_v_t     ra;
    for (int i = 0; i < P2_CYCLES; i++) begin
      r   = rand_word();
      wa0 = rand_addr();
      wa1 = (r[2:0] == 3'd0) ? wa0 : rand_addr();
      set_write(0, r[3], wa0, rand_word(), rand_word());
      set_write(1, r[4], wa1, rand_word(), rand_word());
      for (int p = 0; p < `MRNW_NUM_RD; p++) begin
        do ra = rand_addr(); while ((ra == wa0) || (ra == wa1));
        set_read(p, r[5 + p], ra);
      end
      run_cycle();
    end
  endtask

  // Eight hot addresses spread over all banks, fewer than enough to avoid evictions.
  function automatic addr_v_t hot_addr();
    logic [31:0] r;
    r = $random(seed);
    return {r[1:0], 5'h0a, r[2]};
  endfunction

  task automatic collide_hot_set();
    logic [31:0] r;
    for (int i = 0; i < P3_CYCLES; i++) begin
      r = rand_word();
      set_write(0, r[1:0] != 2'd0, hot_addr(), rand_word(), rand_word());
      set_write(1, r[3:2] != 2'd0, hot_addr(), rand_word(), rand_word());
      set_read(0, r[5:4] != 2'd0, hot_addr());
      set_read(1, r[7:6] != 2'd0, hot_addr());
      run_cycle();
    end
  endtask

  task automatic check_forwarding();
    addr_v_t x;
    for (int i = 0; i < P4_ITERS; i++) begin
      x = rand_addr();
      clear_next();
      set_write(0, 1'b1, x, rand_word(), rand_word());
      set_read(0, 1'b1, x);
      run_cycle();
      clear_next();
      set_read(0, 1'b1, rand_addr());
      set_read(1, 1'b1, x);  // Must come back with the forward flag set.
      run_cycle();
    end
  endtask

  task automatic dual_write_priority();
    addr_v_t x;
    for (int i = 0; i < P5_ITERS; i++) begin
      x = rand_addr();
      clear_next();
      set_write(0, 1'b1, x, rand_word(), rand_word());
      set_write(1, 1'b1, x, rand_word(), rand_word());
      run_cycle();
      clear_next();
      set_read(0, 1'b1, x);
      run_cycle();
    end
  endtask

  initial begin
    seed      = 32'h1e2c637a;
    rst       = 1'b1;
    any_coll  = 1'b0;
    coll_prev = '0;
    clear_next();
    wr_cmd = nxt_wr;
    rd_cmd = nxt_rd;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    fill_memory();
    read_all();
    random_writes();
    collide_hot_set();
    check_forwarding();
    dual_write_priority();
    clear_next();
    repeat (DRAIN_CYCLES) run_cycle();
    $display("*** PASSED ***");
    $finish;
  end

  initial begin
    #(2 * TOTAL_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles", 2 * TOTAL_CYCLES);
    $display("*** FAILED ***");
    $fatal(1, "Watchdog expired.");
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the multiport memory testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_mrnw -f tb.f -o sim_mrnw \
  || { echo "Build failed"; exit 1; }
out=$(./obj_dir/sim_mrnw 2>&1)
echo "$out"
echo "$out" | grep -qF '*** PASSED ***' && echo "Simulation run passed" \
  || { echo "Simulation run failed"; exit 1; }

// ==== source/bank_router.sv ====
`timescale 1ns/10ps
`include "mrnw_defs.svh"

module bank_router import mrnw_pkg::*; (
  input  wr_cmd_t mem_wr [`MRNW_NUM_WR],
  input  rd_cmd_t rd_cmd [`MRNW_NUM_RD],
  output logic [`MRNW_NUM_BANK-1:0][`MRNW_NUM_WR-1:0] bank_we,
  output row_t  [`MRNW_NUM_BANK-1:0][`MRNW_NUM_WR-1:0] bank_wrow,
  output mask_t [`MRNW_NUM_BANK-1:0][`MRNW_NUM_WR-1:0] bank_wmask,
  output data_t [`MRNW_NUM_BANK-1:0][`MRNW_NUM_WR-1:0] bank_wdata,
  output logic [`MRNW_NUM_BANK-1:0][`MRNW_NUM_RD-1:0] bank_re,
  output row_t  [`MRNW_NUM_BANK-1:0][`MRNW_NUM_RD-1:0] bank_rrow
);

  // Row, mask and data fan out to every bank. Only the addressed bank gets an enable.
  always_comb begin
    for (int b = 0; b < `MRNW_NUM_BANK; b++) begin
      for (int w = 0; w < `MRNW_NUM_WR; w++) begin
        bank_we[b][w]    = mem_wr[w].wr && (mem_wr[w].addr.bank == bank_t'(b));
        bank_wrow[b][w]  = mem_wr[w].addr.row;
        bank_wmask[b][w] = mem_wr[w].mask;
        bank_wdata[b][w] = mem_wr[w].data;
      end
    end
  end

  always_comb begin
    for (int b = 0; b < `MRNW_NUM_BANK; b++) begin
      for (int r = 0; r < `MRNW_NUM_RD; r++) begin
        bank_re[b][r]   = rd_cmd[r].rd && (rd_cmd[r].addr.bank == bank_t'(b));
        bank_rrow[b][r] = rd_cmd[r].addr.row;
      end
    end
  end

endmodule

// ==== source/bank_sram.sv ====
`timescale 1ns/10ps
`include "mrnw_defs.svh"

module bank_sram import mrnw_pkg::*; (
  input  logic clk,
  input  logic  [`MRNW_NUM_BANK-1:0][`MRNW_NUM_WR-1:0] bank_we,
  input  row_t  [`MRNW_NUM_BANK-1:0][`MRNW_NUM_WR-1:0] bank_wrow,
  input  mask_t [`MRNW_NUM_BANK-1:0][`MRNW_NUM_WR-1:0] bank_wmask,
  input  data_t [`MRNW_NUM_BANK-1:0][`MRNW_NUM_WR-1:0] bank_wdata,
  input  logic  [`MRNW_NUM_BANK-1:0][`MRNW_NUM_RD-1:0] bank_re,
  input  row_t  [`MRNW_NUM_BANK-1:0][`MRNW_NUM_RD-1:0] bank_rrow,
  output data_t [`MRNW_NUM_BANK-1:0][`MRNW_NUM_RD-1:0] bank_dout
);

  data_t mem_arr [`MRNW_NUM_BANK][1 << `MRNW_ROW_BITS];
  data_t rd_pipe [`MRNW_NUM_BANK][`MRNW_NUM_RD][`MRNW_SRAM_DELAY];

  // Word after ports 0..w have been applied in order, so a higher port wins on shared bits.
  function automatic data_t merged_word(int b, int w);
    data_t word;
    word = mem_arr[b][bank_wrow[b][w]];
    for (int p = 0; p <= w; p++) begin
      if (bank_we[b][p] && (bank_wrow[b][p] == bank_wrow[b][w])) begin
        word = (word & ~bank_wmask[b][p]) | (bank_wdata[b][p] & bank_wmask[b][p]);
      end
    end
    return word;
  endfunction

  always_ff @(posedge clk) begin
    for (int b = 0; b < `MRNW_NUM_BANK; b++) begin
      for (int w = 0; w < `MRNW_NUM_WR; w++) begin
        if (bank_we[b][w]) begin
          mem_arr[b][bank_wrow[b][w]] <= merged_word(b, w);
        end
      end
      // The array is sampled before this edge's writes land.
      for (int r = 0; r < `MRNW_NUM_RD; r++) begin
        if (bank_re[b][r]) begin
          rd_pipe[b][r][0] <= mem_arr[b][bank_rrow[b][r]];
        end
        for (int s = 1; s < `MRNW_SRAM_DELAY; s++) begin
          rd_pipe[b][r][s] <= rd_pipe[b][r][s-1];
        end
      end
    end
  end

  always_comb begin
    for (int b = 0; b < `MRNW_NUM_BANK; b++) begin
      for (int r = 0; r < `MRNW_NUM_RD; r++) begin
        bank_dout[b][r] = rd_pipe[b][r][`MRNW_SRAM_DELAY-1];
      end
    end
  end

endmodule

// ==== source/mrnw_defs.svh ====
`ifndef MRNW_DEFS_SVH
`define MRNW_DEFS_SVH

// Port counts of the logical memory.
`define MRNW_NUM_RD 2
`define MRNW_NUM_WR 2

// Data word width in bits.
`define MRNW_WIDTH 32

// Address split into bank and row fields, 4 x 64 = 256 words.
`define MRNW_NUM_BANK 4
`define MRNW_BANK_BITS 2
`define MRNW_ROW_BITS 6
`define MRNW_ADDR_BITS 8

// One entry per port beyond the first, enough for every collision.
`define MRNW_CACHE_DEPTH 3

// Read latency of a bank SRAM in clock cycles.
`define MRNW_SRAM_DELAY 2

`endif

// ==== source/mrnw_mem.sv ====
`timescale 1ns/10ps
`include "mrnw_defs.svh"

module mrnw_mem import mrnw_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  wr_cmd_t   wr_cmd  [`MRNW_NUM_WR],
  input  rd_cmd_t   rd_cmd  [`MRNW_NUM_RD],
  output data_t     rd_dout [`MRNW_NUM_RD],
  output logic      [`MRNW_NUM_RD-1:0] rd_fwrd,
  output mem_addr_t rd_padr [`MRNW_NUM_RD]
);

  wr_cmd_t mem_wr [`MRNW_NUM_WR];  // Writes after the cache has parked or flushed.
  fwd_t    fwd    [`MRNW_NUM_RD];

  logic  [`MRNW_NUM_BANK-1:0][`MRNW_NUM_WR-1:0] bank_we;
  row_t  [`MRNW_NUM_BANK-1:0][`MRNW_NUM_WR-1:0] bank_wrow;
  mask_t [`MRNW_NUM_BANK-1:0][`MRNW_NUM_WR-1:0] bank_wmask;
  data_t [`MRNW_NUM_BANK-1:0][`MRNW_NUM_WR-1:0] bank_wdata;
  logic  [`MRNW_NUM_BANK-1:0][`MRNW_NUM_RD-1:0] bank_re;
  row_t  [`MRNW_NUM_BANK-1:0][`MRNW_NUM_RD-1:0] bank_rrow;
  data_t [`MRNW_NUM_BANK-1:0][`MRNW_NUM_RD-1:0] bank_dout;

  pseudo_port_cache u_cache (
    .clk    (clk),
    .rst    (rst),
    .wr_cmd (wr_cmd),
    .rd_cmd (rd_cmd),
    .mem_wr (mem_wr),
    .fwd    (fwd)
  );

  bank_router u_router (
    .mem_wr     (mem_wr),
    .rd_cmd     (rd_cmd),
    .bank_we    (bank_we),
    .bank_wrow  (bank_wrow),
    .bank_wmask (bank_wmask),
    .bank_wdata (bank_wdata),
    .bank_re    (bank_re),
    .bank_rrow  (bank_rrow)
  );

  bank_sram u_sram (
    .clk        (clk),
    .bank_we    (bank_we),
    .bank_wrow  (bank_wrow),
    .bank_wmask (bank_wmask),
    .bank_wdata (bank_wdata),
    .bank_re    (bank_re),
    .bank_rrow  (bank_rrow),
    .bank_dout  (bank_dout)
  );

  read_return u_return (
    .clk       (clk),
    .rst       (rst),
    .rd_cmd    (rd_cmd),
    .fwd       (fwd),
    .bank_dout (bank_dout),
    .rd_dout   (rd_dout),
    .rd_fwrd   (rd_fwrd),
    .rd_padr   (rd_padr)
  );

endmodule

// ==== source/mrnw_pkg.sv ====
`include "mrnw_defs.svh"

package mrnw_pkg;

  typedef logic [`MRNW_WIDTH-1:0]     data_t;
  typedef logic [`MRNW_WIDTH-1:0]     mask_t;  // A set bit is written.
  typedef logic [`MRNW_BANK_BITS-1:0] bank_t;
  typedef logic [`MRNW_ROW_BITS-1:0]  row_t;

  // Bank sits in the upper bits, so the struct reads as a flat address.
  typedef struct packed {
    bank_t bank;
    row_t  row;
  } mem_addr_t;

  typedef struct packed {
    logic      wr;
    mem_addr_t addr;
    mask_t     mask;
    data_t     data;
  } wr_cmd_t;

  typedef struct packed {
    logic      rd;
    mem_addr_t addr;
  } rd_cmd_t;

  typedef struct packed {
    logic  hit;
    mask_t mask;
    data_t data;
  } fwd_t;

endpackage

// ==== source/pseudo_port_cache.sv ====
`timescale 1ns/10ps
`include "mrnw_defs.svh"

module pseudo_port_cache import mrnw_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  wr_cmd_t wr_cmd [`MRNW_NUM_WR],
  input  rd_cmd_t rd_cmd [`MRNW_NUM_RD],
  output wr_cmd_t mem_wr [`MRNW_NUM_WR],
  output fwd_t    fwd    [`MRNW_NUM_RD]
);

  // An entry has the layout of a write command. Its strobe bit is the valid flag.
  wr_cmd_t ent_q [`MRNW_CACHE_DEPTH];
  wr_cmd_t ent_d [`MRNW_CACHE_DEPTH];

  logic [`MRNW_CACHE_DEPTH-1:0] used;  // Entry is claimed this cycle.
  logic [`MRNW_NUM_WR-1:0]      merged;
  logic [`MRNW_NUM_WR-1:0]      coll;  // Write meets a read at the same address.
  logic [`MRNW_NUM_WR-1:0]      park;
  logic [`MRNW_NUM_WR-1:0]      park_found;

  always_comb begin
    ent_d      = ent_q;
    used       = '0;
    merged     = '0;
    coll       = '0;
    park       = '0;
    park_found = '0;

    // A read that hits an entry pins it, so it is never chosen for eviction.
    for (int r = 0; r < `MRNW_NUM_RD; r++) begin
      for (int e = 0; e < `MRNW_CACHE_DEPTH; e++) begin
        if (rd_cmd[r].rd && ent_q[e].wr && (ent_q[e].addr == rd_cmd[r].addr)) begin
          used[e] = 1'b1;
        end
      end
    end

    for (int w = 0; w < `MRNW_NUM_WR; w++) begin
      mem_wr[w] = wr_cmd[w];

      // Matching runs on the updated entries. Port 1 then folds into an entry
      // that port 0 parked in this cycle, and its bits win.
      for (int e = 0; e < `MRNW_CACHE_DEPTH; e++) begin
        if (wr_cmd[w].wr && ent_d[e].wr && (ent_d[e].addr == wr_cmd[w].addr)) begin
          ent_d[e].mask = ent_d[e].mask | wr_cmd[w].mask;
          ent_d[e].data = (ent_d[e].data & ~wr_cmd[w].mask) |
                          (wr_cmd[w].data & wr_cmd[w].mask);
          used[e]   = 1'b1;
          merged[w] = 1'b1;
        end
      end

      for (int r = 0; r < `MRNW_NUM_RD; r++) begin
        if (wr_cmd[w].wr && rd_cmd[r].rd && (rd_cmd[r].addr == wr_cmd[w].addr)) begin
          coll[w] = 1'b1;
        end
      end

      park[w] = coll[w] && !merged[w];
      if (merged[w]) begin
        mem_wr[w].wr = 1'b0;  // Data now lives in the cache only.
      end

      // Parking frees the memory write port, which carries the evicted entry.
      for (int e = 0; e < `MRNW_CACHE_DEPTH; e++) begin
        if (park[w] && !park_found[w] && !used[e]) begin
          mem_wr[w]     = ent_q[e];  // No write if the entry was empty.
          ent_d[e]      = wr_cmd[w];
          used[e]       = 1'b1;
          park_found[w] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int e = 0; e < `MRNW_CACHE_DEPTH; e++) begin
      ent_q[e].addr <= ent_d[e].addr;
      ent_q[e].mask <= ent_d[e].mask;
      ent_q[e].data <= ent_d[e].data;
      if (rst) begin
        ent_q[e].wr <= 1'b0;
      end else begin
        ent_q[e].wr <= ent_d[e].wr;
      end
    end
  end

  // Lookup uses the registered entries, which hold the state before this cycle's writes.
  always_comb begin
    for (int r = 0; r < `MRNW_NUM_RD; r++) begin
      fwd[r] = '0;
      for (int e = 0; e < `MRNW_CACHE_DEPTH; e++) begin
        if (rd_cmd[r].rd && ent_q[e].wr && (ent_q[e].addr == rd_cmd[r].addr)) begin
          fwd[r].hit  = 1'b1;
          fwd[r].mask = ent_q[e].mask;
          fwd[r].data = ent_q[e].data;
        end
      end
    end
  end

endmodule

// ==== source/read_return.sv ====
`timescale 1ns/10ps
`include "mrnw_defs.svh"

module read_return import mrnw_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  rd_cmd_t   rd_cmd [`MRNW_NUM_RD],
  input  fwd_t      fwd    [`MRNW_NUM_RD],
  input  data_t     [`MRNW_NUM_BANK-1:0][`MRNW_NUM_RD-1:0] bank_dout,
  output data_t     rd_dout [`MRNW_NUM_RD],
  output logic      [`MRNW_NUM_RD-1:0] rd_fwrd,
  output mem_addr_t rd_padr [`MRNW_NUM_RD]
);

  // Tags travel alongside the SRAM read so both arrive in the same cycle.
  mem_addr_t addr_pipe [`MRNW_NUM_RD][`MRNW_SRAM_DELAY];
  fwd_t      fwd_pipe  [`MRNW_NUM_RD][`MRNW_SRAM_DELAY];
  data_t     bank_word [`MRNW_NUM_RD];

  always_ff @(posedge clk) begin
    for (int r = 0; r < `MRNW_NUM_RD; r++) begin
      addr_pipe[r][0]     <= rd_cmd[r].addr;
      fwd_pipe[r][0].mask <= fwd[r].mask;
      fwd_pipe[r][0].data <= fwd[r].data;
      if (rst) begin
        fwd_pipe[r][0].hit <= 1'b0;
      end else begin
        fwd_pipe[r][0].hit <= fwd[r].hit;
      end
      for (int s = 1; s < `MRNW_SRAM_DELAY; s++) begin
        addr_pipe[r][s]     <= addr_pipe[r][s-1];
        fwd_pipe[r][s].mask <= fwd_pipe[r][s-1].mask;
        fwd_pipe[r][s].data <= fwd_pipe[r][s-1].data;
        if (rst) begin
          fwd_pipe[r][s].hit <= 1'b0;
        end else begin
          fwd_pipe[r][s].hit <= fwd_pipe[r][s-1].hit;
        end
      end
    end
  end

  always_comb begin
    for (int r = 0; r < `MRNW_NUM_RD; r++) begin
      bank_word[r] = bank_dout[addr_pipe[r][`MRNW_SRAM_DELAY-1].bank][r];
      rd_padr[r]   = addr_pipe[r][`MRNW_SRAM_DELAY-1];
      rd_fwrd[r]   = fwd_pipe[r][`MRNW_SRAM_DELAY-1].hit;
      if (fwd_pipe[r][`MRNW_SRAM_DELAY-1].hit) begin
        // Cached bits overlay the bank word.
        rd_dout[r] = (bank_word[r] & ~fwd_pipe[r][`MRNW_SRAM_DELAY-1].mask) |
                     (fwd_pipe[r][`MRNW_SRAM_DELAY-1].data &
                      fwd_pipe[r][`MRNW_SRAM_DELAY-1].mask);
      end else begin
        rd_dout[r] = bank_word[r];
      end
    end
  end

endmodule

// ==== tb.f ====
+incdir+source
source/mrnw_pkg.sv
source/pseudo_port_cache.sv
source/bank_router.sv
source/bank_sram.sv
source/read_return.sv
source/mrnw_mem.sv
dv/mrnw_asserts.sv
dv/tb_mrnw.sv
